//--- verilog.f
+incdir+verilog
verilog/lcd_pkg.sv
verilog/lcd_regs.sv
verilog/lcd_fifo.sv
verilog/lcd_bus_seq.sv
verilog/lcd_ctrl_top.sv
sim/tb_clock.sv
sim/lcd_ctrl_assertions.sv
sim/lcd_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= lcd_ctrl_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/lcd_ctrl_tb.sv
//--------------------
// table driven testbench, beats checked on each rising panel_wrn
// timing is only rewritten while the bus is idle
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_ctrl_tb;

  localparam int K_WR  = 0;
  localparam int K_RD  = 1;
  localparam int K_PIN = 2;
  localparam int K_CMD = 3;
  localparam int K_TE  = 4;
  localparam int K_END = 5;   // expv bits select the extra checks

  typedef struct packed {
    int                  kind;
    lcd_pkg::lcd_addr_t  addr;
    lcd_pkg::lcd_word_t  data;
    lcd_pkg::lcd_word_t  expv;
  } entry_t;

  logic                aclk;
  logic                arstn;
  logic                reg_valid;
  logic                reg_ready;
  logic                reg_write;
  lcd_pkg::lcd_addr_t  reg_addr;
  lcd_pkg::lcd_word_t  reg_wdata;
  lcd_pkg::lcd_word_t  reg_rdata;
  logic                panel_rstn;
  logic                panel_csn;
  logic                panel_dc;
  logic                panel_wrn;
  logic                panel_oe;
  lcd_pkg::lcd_beat_t  panel_data;
  logic                te;
  logic                int_strb;

  entry_t       tbl[$];
  logic [16:0]  exp_q[$];   // {dc, data}
  int seed = 49;
  int errors = 0;
  int test_err = 0;
  int tests = 0;
  int failed = 0;
  int cyc = 0;
  int exp_low = 0;
  int exp_high = 0;
  int exp_delay = 0;
  int fall_c = 0;
  int rise_c = 0;
  int have_rise = 0;
  int gap = 0;
  int min_gap = 1000000;
  int int_cnt = 0;
  int int_c = 0;
  int int_base = 0;
  int te_c = 0;
  int te_fall_c = 0;
  int te_armed = 0;
  int stall_cnt = 0;

  tb_clock u_clk (.aclk(aclk), .arstn(arstn));

  lcd_ctrl_top UUT (
    .aclk(aclk), .arstn(arstn),
    .reg_valid(reg_valid), .reg_ready(reg_ready), .reg_write(reg_write),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .panel_rstn(panel_rstn), .panel_csn(panel_csn), .panel_dc(panel_dc),
    .panel_wrn(panel_wrn), .panel_oe(panel_oe), .panel_data(panel_data),
    .te(te), .int_strb(int_strb)
  );

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
    test_err++;
  endtask

  always @(posedge aclk) begin
    cyc = cyc + 1;
    if (arstn && int_strb) begin
      int_cnt++;
      int_c = cyc;
    end
  end

  always @(negedge panel_wrn) begin
    if (arstn) begin
      fall_c = cyc;
      if (have_rise != 0) begin
        gap = cyc - rise_c;
        if (gap < exp_high + 1) begin
          note_error($sformatf("** Error at %0t: panel_wrn high cycles expected >= %0d got %0d",
                               $time, exp_high + 1, gap));
        end
        if (gap < min_gap) min_gap = gap;
      end
      if (te_armed != 0 && te_fall_c == 0) te_fall_c = cyc;
    end
  end

  // beat monitor
  always @(posedge panel_wrn) begin
    if (arstn) begin
      rise_c = cyc;
      have_rise = 1;
      if (cyc - fall_c != exp_low + 1) begin
        note_error($sformatf("** Error at %0t: panel_wrn low cycles expected %0d got %0d",
                             $time, exp_low + 1, cyc - fall_c));
      end
      if (panel_oe !== 1'b1) begin
        note_error($sformatf("** Error at %0t: panel_oe expected 1 got %b", $time, panel_oe));
      end
      if (exp_q.size() == 0) begin
        note_error($sformatf("beat %h at %0t arrived with none expected", panel_data, $time));
      end else if ({panel_dc, panel_data} !== exp_q[0]) begin
        note_error($sformatf("** Error at %0t: {panel_dc,panel_data} expected %h got %h",
                             $time, exp_q[0], {panel_dc, panel_data}));
        void'(exp_q.pop_front());
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  // called 1 ns after an edge, returns 1 ns after the transfer edge
  task automatic reg_access(input logic wr, input lcd_pkg::lcd_addr_t a,
                            input lcd_pkg::lcd_word_t d, output lcd_pkg::lcd_word_t rd);
    logic done;
    done = 1'b0;
    rd = '0;
    reg_valid = 1'b1;
    reg_write = wr;
    reg_addr  = a;
    reg_wdata = d;
    while (!done) begin
      @(posedge aclk);
      if (reg_ready) begin
        done = 1'b1;
        rd = reg_rdata;
      end else begin
        stall_cnt++;
      end
    end
    #1;
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic push_cmd(input lcd_pkg::lcd_word_t w);
    lcd_pkg::lcd_word_t rd;
    lcd_pkg::lcd_word_t dw;
    int n;
    int beats;
    n = {8'h00, w[23:0]};
    if (w[31:30] == 2'd2) begin
      beats = (n + 1) / 2;
      if (beats == 0) beats = 1;
      for (int k = 0; k < (beats + 1) / 2; k++) begin
        dw = $random(seed);
        reg_access(1'b1, `LCD_DATA_FIFO_OFS, dw, rd);   // data queued ahead of command
        exp_q.push_back({1'b1, dw[15:0]});
        if (2 * k + 1 < beats) exp_q.push_back({1'b1, dw[31:16]});
      end
    end else if (w[31:30] != 2'd3) begin
      exp_q.push_back({w[30], w[15:0]});
    end
    reg_access(1'b1, `LCD_CMD_FIFO_OFS, w, rd);
  endtask

  task automatic finish_test(input lcd_pkg::lcd_word_t flags);
    while (exp_q.size() != 0 || panel_oe) @(posedge aclk);
    repeat (4) @(posedge aclk);
    #1;
    if (flags[0] && min_gap != exp_high + 1) begin
      note_error($sformatf("** Error at %0t: panel_wrn high cycles in run expected %0d got %0d",
                           $time, exp_high + 1, min_gap));
    end
    if (flags[1]) begin
      if (int_cnt - int_base != 1) begin
        note_error($sformatf("** Error at %0t: int_strb pulses expected 1 got %0d",
                             $time, int_cnt - int_base));
      end else if (int_c >= fall_c) begin
        note_error("int_strb pulse came after the following beat started");
      end
    end
    if (flags[2]) begin
      if (te_fall_c == 0) begin
        note_error("no beat followed the te rising edge");
      end else if (te_fall_c - te_c < exp_delay) begin
        note_error($sformatf("** Error at %0t: te to beat cycles expected >= %0d got %0d",
                             $time, exp_delay, te_fall_c - te_c));
      end
      te = 1'b0;
      te_armed = 0;
    end
    if (flags[3] && stall_cnt == 0) note_error("reg_ready never stalled under back-pressure");
    tests++;
    if (test_err != 0) failed++;
    $display("test %0d: %s, %0d errors", tests, (test_err == 0) ? "ok" : "bad", test_err);
    test_err = 0;
    min_gap = 1000000;
    have_rise = 0;   // next test may bring new timing
    int_base = int_cnt;
    stall_cnt = 0;
  endtask

  task automatic apply_entry(input entry_t e);
    lcd_pkg::lcd_word_t rd;
    case (e.kind)
      K_WR: begin
        reg_access(1'b1, e.addr, e.data, rd);
        if (e.addr == `LCD_TIMING_OFS) begin
          exp_low  = {24'h0, e.data[7:0]};
          exp_high = {24'h0, e.data[15:8]};
        end
        if (e.addr == `LCD_CONTROL_OFS) exp_delay = {16'h0, e.data[31:16]};
      end
      K_RD: begin
        reg_access(1'b0, e.addr, '0, rd);
        if (rd !== e.expv) begin
          note_error($sformatf("** Error at %0t: reg_rdata @%h expected %h got %h",
                               $time, e.addr, e.expv, rd));
        end
      end
      K_PIN: begin
        if ({panel_rstn, panel_csn} !== e.expv[1:0]) begin
          note_error($sformatf("** Error at %0t: {panel_rstn,panel_csn} expected %b got %b",
                               $time, e.expv[1:0], {panel_rstn, panel_csn}));
        end
      end
      K_CMD: push_cmd(e.data);
      K_TE: begin
        repeat (40) @(posedge aclk);
        #1;
        if (exp_q.size() != e.data) note_error("beat went out before te rose");
        te = 1'b1;
        te_c = cyc;
        te_fall_c = 0;
        te_armed = 1;
      end
      default: finish_test(e.expv);
    endcase
  endtask

  task automatic add(input int kind, input lcd_pkg::lcd_addr_t a,
                     input lcd_pkg::lcd_word_t d, input lcd_pkg::lcd_word_t x);
    tbl.push_back('{kind, a, d, x});
  endtask

  task automatic build_table();
    add(K_RD,  `LCD_VERSION_OFS, 0, `LCD_VERSION);
    add(K_PIN, 0, 0, 32'h1);
    add(K_WR,  `LCD_TIMING_OFS, 32'hAAAA_0201, 0);
    add(K_RD,  `LCD_TIMING_OFS, 0, 32'h0000_0201);
    add(K_WR,  `LCD_CONTROL_OFS, 32'h0005_FFFF, 0);
    add(K_RD,  `LCD_CONTROL_OFS, 0, 32'h0005_0010);
    add(K_WR,  `LCD_CSN_OFS, 32'h0, 0);
    add(K_RD,  `LCD_CSN_OFS, 0, 32'h0);
    add(K_PIN, 0, 0, 32'h2);
    add(K_RD,  8'h0C, 0, 32'h0);   // unmapped
    add(K_END, 0, 0, 0);
    add(K_CMD, 0, 32'h0000_002C, 0);
    add(K_CMD, 0, 32'h4000_1234, 0);
    add(K_CMD, 0, 32'h0000_0029, 0);
    add(K_END, 0, 0, 0);
    add(K_CMD, 0, 32'h8000_0001, 0);
    add(K_CMD, 0, 32'h8000_0004, 0);
    add(K_CMD, 0, 32'h8000_0007, 0);
    add(K_END, 0, 0, 0);
    add(K_WR,  `LCD_TIMING_OFS, 32'h0000_1414, 0);
    for (int i = 0; i < 10; i++) add(K_CMD, 0, 32'h4000_0100 + i, 0);
    add(K_END, 0, 0, 32'h8);
    add(K_WR,  `LCD_TIMING_OFS, 32'h0000_0101, 0);
    add(K_CMD, 0, 32'hC000_0001, 0);
    add(K_CMD, 0, 32'h0000_00AA, 0);
    add(K_END, 0, 0, 32'h2);
    add(K_WR,  `LCD_CONTROL_OFS, 32'h0010_0010, 0);
    add(K_CMD, 0, 32'hC000_0002, 0);
    add(K_CMD, 0, 32'h0000_00BB, 0);
    add(K_TE,  0, 1, 0);
    add(K_END, 0, 0, 32'h4);
    add(K_WR,  `LCD_TIMING_OFS, 32'h0000_0302, 0);
    add(K_CMD, 0, 32'h8000_0008, 0);
    add(K_END, 0, 0, 32'h1);
    add(K_WR,  `LCD_TIMING_OFS, 32'h0000_0005, 0);
    add(K_CMD, 0, 32'h8000_0006, 0);
    add(K_END, 0, 0, 32'h1);
  endtask

  initial begin
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    te        = 1'b0;
    build_table();
    wait (arstn);
    @(posedge aclk);
    #1;
    foreach (tbl[i]) apply_entry(tbl[i]);
    errors = errors + UUT.u_assertions.fail_cnt;   // bound assertion failures
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests, tests - failed, failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog, 200 cycles per table entry
  initial begin
    #1;
    #(tbl.size() * 200 * 8);
    $display("watchdog expired before the table finished");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/lcd_ctrl_assertions.sv
//--------------------
// strobe widths, beat data hold and host handshake stability
// high width is a lower bound since idle gaps stretch it
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_ctrl_assertions (
  input logic                aclk,
  input logic                arstn,
  input logic                panel_wrn,
  input lcd_pkg::lcd_beat_t  panel_data,
  input lcd_pkg::lcd_len_t   wr_low_len,
  input lcd_pkg::lcd_len_t   wr_high_len,
  input logic                reg_valid,
  input logic                reg_ready,
  input logic                reg_write,
  input lcd_pkg::lcd_addr_t  reg_addr,
  input lcd_pkg::lcd_word_t  reg_wdata
);

  logic [8:0] low_cnt;
  logic [8:0] high_cnt;   // saturates
  logic       timing_wr;
  int         fail_cnt = 0;

  assign timing_wr = reg_valid && reg_ready && reg_write && (reg_addr == `LCD_TIMING_OFS);

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      low_cnt  <= '0;
      high_cnt <= '1;
    end else begin
      low_cnt <= panel_wrn ? 9'd0 : low_cnt + 9'd1;
      if (!panel_wrn) begin
        high_cnt <= '0;
      end else if (timing_wr) begin
        high_cnt <= '1;   // idle gap before new lengths
      end else if (high_cnt != '1) begin
        high_cnt <= high_cnt + 9'd1;
      end
    end
  end

  low_width: assert property (@(posedge aclk) disable iff (!arstn)
    $rose(panel_wrn) |-> (low_cnt == {1'b0, wr_low_len} + 9'd1))
    else begin
      $error("panel_wrn low width differs from wr_low_len+1");
      fail_cnt++;
    end

  high_width: assert property (@(posedge aclk) disable iff (!arstn)
    $fell(panel_wrn) |-> (high_cnt >= {1'b0, wr_high_len} + 9'd1))
    else begin
      $error("panel_wrn high width shorter than wr_high_len+1");
      fail_cnt++;
    end

  data_hold: assert property (@(posedge aclk) disable iff (!arstn)
    (!panel_wrn && $past(!panel_wrn)) |-> $stable(panel_data))
    else begin
      $error("panel_data changed while panel_wrn low");
      fail_cnt++;
    end

  host_hold: assert property (@(posedge aclk) disable iff (!arstn)
    (reg_valid && !reg_ready) |=>
      (reg_valid && $stable(reg_write) && $stable(reg_addr) && $stable(reg_wdata)))
    else begin
      $error("host request changed while stalled");
      fail_cnt++;
    end

endmodule

bind lcd_ctrl_top lcd_ctrl_assertions u_assertions (
  .aclk        (aclk),
  .arstn       (arstn),
  .panel_wrn   (panel_wrn),
  .panel_data  (panel_data),
  .wr_low_len  (wr_low_len),
  .wr_high_len (wr_high_len),
  .reg_valid   (reg_valid),
  .reg_ready   (reg_ready),
  .reg_write   (reg_write),
  .reg_addr    (reg_addr),
  .reg_wdata   (reg_wdata)
);

`default_nettype wire

//--- sim/tb_clock.sv
//--------------------
// 8 ns clock, reset low for the first 10 cycles
//--------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic aclk,
  output logic arstn
);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  initial begin
    arstn = 1'b0;
    repeat (10) @(posedge aclk);
    #1 arstn = 1'b1;   // release off the edge
  end

endmodule

`default_nettype wire

//--- verilog/lcd_ctrl_top.sv
//--------------------
// i8080 panel controller, 16 bit bus, write only
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_ctrl_top (
  input  logic                aclk,
  input  logic                arstn,
  input  logic                reg_valid,
  output logic                reg_ready,
  input  logic                reg_write,
  input  lcd_pkg::lcd_addr_t  reg_addr,
  input  lcd_pkg::lcd_word_t  reg_wdata,
  output lcd_pkg::lcd_word_t  reg_rdata,
  output logic                panel_rstn,
  output logic                panel_csn,
  output logic                panel_dc,
  output logic                panel_wrn,
  output logic                panel_oe,
  output lcd_pkg::lcd_beat_t  panel_data,
  input  logic                te,
  output logic                int_strb
);

  logic [`LCD_NUM_FIFOS-1:0]  fifo_push;
  logic [`LCD_NUM_FIFOS-1:0]  fifo_full;
  logic [`LCD_NUM_FIFOS-1:0]  fifo_pop;
  logic [`LCD_NUM_FIFOS-1:0]  fifo_empty;
  lcd_pkg::lcd_word_t         fifo_head [`LCD_NUM_FIFOS];
  lcd_pkg::lcd_word_t         push_data;
  lcd_pkg::lcd_len_t          wr_low_len;
  lcd_pkg::lcd_len_t          wr_high_len;
  lcd_pkg::lcd_delay_t        te_delay;

  lcd_regs u_regs (
    .aclk        (aclk),
    .arstn       (arstn),
    .reg_valid   (reg_valid),
    .reg_write   (reg_write),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_ready   (reg_ready),
    .reg_rdata   (reg_rdata),
    .fifo_full   (fifo_full),
    .fifo_push   (fifo_push),
    .push_data   (push_data),
    .wr_low_len  (wr_low_len),
    .wr_high_len (wr_high_len),
    .te_delay    (te_delay),
    .panel_rstn  (panel_rstn),
    .panel_csn   (panel_csn)
  );

  for (genvar i = 0; i < `LCD_NUM_FIFOS; i++) begin : g_fifo   // cmd, data
    lcd_fifo u_fifo (
      .aclk      (aclk),
      .arstn     (arstn),
      .push      (fifo_push[i]),
      .push_data (push_data),
      .full      (fifo_full[i]),
      .pop       (fifo_pop[i]),
      .head      (fifo_head[i]),
      .empty     (fifo_empty[i])
    );
  end

  lcd_bus_seq u_seq (
    .aclk        (aclk),
    .arstn       (arstn),
    .cmd_head    (fifo_head[`LCD_CMD_FIFO]),
    .data_head   (fifo_head[`LCD_DATA_FIFO]),
    .cmd_empty   (fifo_empty[`LCD_CMD_FIFO]),
    .data_empty  (fifo_empty[`LCD_DATA_FIFO]),
    .cmd_pop     (fifo_pop[`LCD_CMD_FIFO]),
    .data_pop    (fifo_pop[`LCD_DATA_FIFO]),
    .wr_low_len  (wr_low_len),
    .wr_high_len (wr_high_len),
    .te_delay    (te_delay),
    .te          (te),
    .panel_dc    (panel_dc),
    .panel_wrn   (panel_wrn),
    .panel_oe    (panel_oe),
    .panel_data  (panel_data),
    .int_strb    (int_strb)
  );

endmodule

`default_nettype wire

//--- verilog/lcd_bus_seq.sv
//--------------------
// te is asynchronous, only its rising edge is used
// a parameter run of 0 or 1 bytes still sends one beat
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_bus_seq (
  input  logic                 aclk,
  input  logic                 arstn,
  input  lcd_pkg::lcd_word_t   cmd_head,
  input  lcd_pkg::lcd_word_t   data_head,
  input  logic                 cmd_empty,
  input  logic                 data_empty,
  output logic                 cmd_pop,
  output logic                 data_pop,
  input  lcd_pkg::lcd_len_t    wr_low_len,
  input  lcd_pkg::lcd_len_t    wr_high_len,
  input  lcd_pkg::lcd_delay_t  te_delay,
  input  logic                 te,
  output logic                 panel_dc,
  output logic                 panel_wrn,
  output logic                 panel_oe,
  output lcd_pkg::lcd_beat_t   panel_data,
  output logic                 int_strb
);

  lcd_pkg::lcd_state_t   state;
  lcd_pkg::lcd_opcode_t  opcode;
  lcd_pkg::lcd_len_t     strobe_cnt;
  lcd_pkg::lcd_count_t   byte_cnt;     // bytes sent before the current beat
  lcd_pkg::lcd_count_t   byte_max;
  lcd_pkg::lcd_word_t    word_q;
  lcd_pkg::lcd_delay_t   delay_cnt;
  logic                  hi_pending;   // high half of word_q still to send
  logic                  more_bytes;
  logic                  beat_end;
  logic [2:0]            te_sync;
  logic                  te_rise;

  assign opcode = lcd_pkg::lcd_opcode_t'(cmd_head[31:30]);

  assign more_bytes = ({1'b0, byte_cnt} + 25'd2) < {1'b0, byte_max};
  assign beat_end   = (state == lcd_pkg::st_wr_high) && (strobe_cnt == wr_high_len);

  assign cmd_pop  = (state == lcd_pkg::st_idle) && !cmd_empty;
  assign data_pop = !data_empty &&
                    ((state == lcd_pkg::st_wait_data) ||
                     (beat_end && more_bytes && !hi_pending));

  // two sync stages plus one for edge detect
  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      te_sync <= '0;
    end else begin
      te_sync <= {te_sync[1:0], te};
    end
  end

  assign te_rise = te_sync[1] && !te_sync[2];

  always_ff @(posedge aclk) begin
    if (data_pop) begin
      word_q <= data_head;
    end
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      state      <= lcd_pkg::st_idle;
      strobe_cnt <= '0;
      byte_cnt   <= '0;
      byte_max   <= '0;
      delay_cnt  <= '0;
      hi_pending <= 1'b0;
      panel_wrn  <= 1'b1;
      panel_oe   <= 1'b0;
      panel_dc   <= 1'b1;
      panel_data <= '0;
      int_strb   <= 1'b0;
    end else begin
      int_strb <= 1'b0;   // single cycle pulse
      case (state)
        lcd_pkg::st_idle: begin
          if (!cmd_empty) begin
            strobe_cnt <= '0;
            byte_cnt   <= '0;
            case (opcode)
              lcd_pkg::op_write_cmd, lcd_pkg::op_write_param: begin
                state      <= lcd_pkg::st_wr_low;
                byte_max   <= '0;
                panel_wrn  <= 1'b0;
                panel_oe   <= 1'b1;
                panel_dc   <= (opcode == lcd_pkg::op_write_param);
                panel_data <= cmd_head[`LCD_BEAT_W-1:0];
              end
              lcd_pkg::op_write_n_param: begin
                state    <= lcd_pkg::st_wait_data;
                byte_max <= cmd_head[23:0];
              end
              lcd_pkg::op_sync: begin
                if (cmd_head[1]) begin
                  state <= lcd_pkg::st_wait_te;
                end else begin
                  state    <= lcd_pkg::st_sync;
                  int_strb <= cmd_head[0];
                end
              end
            endcase
          end
        end

        lcd_pkg::st_wait_data: begin
          if (!data_empty) begin
            state      <= lcd_pkg::st_wr_low;
            hi_pending <= 1'b1;
            panel_wrn  <= 1'b0;
            panel_oe   <= 1'b1;
            panel_dc   <= 1'b1;
            panel_data <= data_head[`LCD_BEAT_W-1:0];   // low half first
          end
        end

        lcd_pkg::st_wr_low: begin
          if (strobe_cnt == wr_low_len) begin
            state      <= lcd_pkg::st_wr_high;
            strobe_cnt <= '0;
            panel_wrn  <= 1'b1;
          end else begin
            strobe_cnt <= strobe_cnt + 1'b1;
          end
        end

        lcd_pkg::st_wr_high: begin
          if (beat_end) begin
            strobe_cnt <= '0;
            if (more_bytes) begin
              byte_cnt <= byte_cnt + 24'd2;
              if (hi_pending) begin
                state      <= lcd_pkg::st_wr_low;
                hi_pending <= 1'b0;
                panel_wrn  <= 1'b0;
                panel_data <= word_q[`LCD_WORD_W-1:`LCD_BEAT_W];
              end else if (!data_empty) begin
                state      <= lcd_pkg::st_wr_low;
                hi_pending <= 1'b1;
                panel_wrn  <= 1'b0;
                panel_data <= data_head[`LCD_BEAT_W-1:0];
              end else begin
                state <= lcd_pkg::st_wait_data;   // bus idles high
              end
            end else begin
              state    <= lcd_pkg::st_idle;
              panel_oe <= 1'b0;
              panel_dc <= 1'b1;
            end
          end else begin
            strobe_cnt <= strobe_cnt + 1'b1;
          end
        end

        lcd_pkg::st_wait_te: begin
          if (te_rise) begin
            state     <= lcd_pkg::st_te_delay;
            delay_cnt <= te_delay;
          end
        end

        lcd_pkg::st_te_delay: begin
          if (delay_cnt == '0) begin
            state <= lcd_pkg::st_idle;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end

        lcd_pkg::st_sync: begin
          state <= lcd_pkg::st_idle;
        end

        default: begin
          state <= lcd_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcd_fifo.sv
//--------------------
// push into a full FIFO or pop from an empty one is dropped
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_fifo (
  input  logic                aclk,
  input  logic                arstn,
  input  logic                push,
  input  lcd_pkg::lcd_word_t  push_data,
  output logic                full,
  input  logic                pop,
  output lcd_pkg::lcd_word_t  head,
  output logic                empty
);

  localparam int DEPTH = 1 << `LCD_FIFO_AW;

  lcd_pkg::lcd_word_t     mem [0:DEPTH-1];
  logic [`LCD_FIFO_AW:0]  wr_ptr;   // msb is the wrap bit
  logic [`LCD_FIFO_AW:0]  rd_ptr;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[`LCD_FIFO_AW] != rd_ptr[`LCD_FIFO_AW]) &&
                 (wr_ptr[`LCD_FIFO_AW-1:0] == rd_ptr[`LCD_FIFO_AW-1:0]);

  assign head = mem[rd_ptr[`LCD_FIFO_AW-1:0]];

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr[`LCD_FIFO_AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcd_regs.sv
//--------------------
// host register port, reads never stall
// FIFO writes hold reg_ready low while the addressed FIFO is full
//--------------------
`timescale 1ns/10ps
`default_nettype none

`include "lcd_params.svh"

module lcd_regs (
  input  logic                       aclk,
  input  logic                       arstn,
  input  logic                       reg_valid,
  input  logic                       reg_write,
  input  lcd_pkg::lcd_addr_t         reg_addr,
  input  lcd_pkg::lcd_word_t         reg_wdata,
  output logic                       reg_ready,
  output lcd_pkg::lcd_word_t         reg_rdata,
  input  logic [`LCD_NUM_FIFOS-1:0]  fifo_full,
  output logic [`LCD_NUM_FIFOS-1:0]  fifo_push,
  output lcd_pkg::lcd_word_t         push_data,
  output lcd_pkg::lcd_len_t          wr_low_len,
  output lcd_pkg::lcd_len_t          wr_high_len,
  output lcd_pkg::lcd_delay_t        te_delay,
  output logic                       panel_rstn,
  output logic                       panel_csn
);

  logic [`LCD_NUM_FIFOS-1:0] fifo_sel;
  logic                      xfer;
  logic                      cfg_wr;

  // which FIFO the address points at, if any
  always_comb begin
    fifo_sel = '0;
    if (reg_addr == `LCD_CMD_FIFO_OFS) begin
      fifo_sel[`LCD_CMD_FIFO] = 1'b1;
    end
    if (reg_addr == `LCD_DATA_FIFO_OFS) begin
      fifo_sel[`LCD_DATA_FIFO] = 1'b1;
    end
  end

  assign reg_ready = !(reg_write && |(fifo_sel & fifo_full));   // stall on full target
  assign xfer      = reg_valid && reg_ready;
  assign cfg_wr    = xfer && reg_write;

  assign fifo_push = cfg_wr ? fifo_sel : '0;
  assign push_data = reg_wdata;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wr_low_len  <= '0;
      wr_high_len <= '0;
      te_delay    <= '0;
      panel_rstn  <= 1'b0;   // panel held in reset
      panel_csn   <= 1'b1;
    end else if (cfg_wr) begin
      case (reg_addr)
        `LCD_TIMING_OFS: begin
          wr_low_len  <= reg_wdata[7:0];
          wr_high_len <= reg_wdata[15:8];
        end
        `LCD_CONTROL_OFS: begin
          te_delay   <= reg_wdata[31:16];
          panel_rstn <= reg_wdata[4];
        end
        `LCD_CSN_OFS: begin
          panel_csn <= reg_wdata[0];
        end
        default: begin
        end
      endcase
    end
  end

  // readback, reserved bits stay zero
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      `LCD_VERSION_OFS: begin
        reg_rdata = `LCD_VERSION;
      end
      `LCD_TIMING_OFS: begin
        reg_rdata[7:0]  = wr_low_len;
        reg_rdata[15:8] = wr_high_len;
      end
      `LCD_CONTROL_OFS: begin
        reg_rdata[31:16] = te_delay;
        reg_rdata[4]     = panel_rstn;
      end
      `LCD_CSN_OFS: begin
        reg_rdata[0] = panel_csn;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/lcd_pkg.sv
//--------------------
// shared types of the panel controller
//--------------------
`default_nettype none

`include "lcd_params.svh"

package lcd_pkg;

  typedef logic [`LCD_WORD_W-1:0] lcd_word_t;
  typedef logic [`LCD_BEAT_W-1:0] lcd_beat_t;
  typedef logic [7:0]             lcd_addr_t;
  typedef logic [7:0]             lcd_len_t;    // cycles minus one
  typedef logic [15:0]            lcd_delay_t;
  typedef logic [23:0]            lcd_count_t;

  // command word bits 31:30
  typedef enum logic [1:0] {
    op_write_cmd     = 2'd0,
    op_write_param   = 2'd1,
    op_write_n_param = 2'd2,
    op_sync          = 2'd3
  } lcd_opcode_t;

  typedef enum logic [2:0] {
    st_idle,
    st_wr_low,
    st_wr_high,
    st_wait_data,
    st_wait_te,
    st_te_delay,
    st_sync
  } lcd_state_t;

endpackage

`default_nettype wire

//--- verilog/lcd_params.svh
//--------------------
// widths, FIFO depth and register map of the i8080 panel controller
// offsets are byte addresses compared in full, no aliasing
//--------------------
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

`define LCD_WORD_W          32
`define LCD_BEAT_W          16
`define LCD_FIFO_AW         2     // 4 entries per FIFO
`define LCD_NUM_FIFOS       2

`define LCD_CMD_FIFO        0
`define LCD_DATA_FIFO       1

`define LCD_VERSION_OFS     8'h00
`define LCD_TIMING_OFS      8'h04
`define LCD_CONTROL_OFS     8'h08
`define LCD_CMD_FIFO_OFS    8'h10
`define LCD_DATA_FIFO_OFS   8'h14
`define LCD_CSN_OFS         8'h18

`define LCD_VERSION         32'h0108_0016

`endif
